// ==== Makefile ====
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= ifu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -- '>>> PASS' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/ifu_consts.svh ====
/*
  Fetch stage constants. RV32 with the C extension only, so PC and word are 32 bits
  Only the encodings the static predictor needs are listed here
*/
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// Datapath widths
`define IFU_PC_W        32
`define IFU_INSTR_W     32

// RV32 major opcodes
`define IFU_OPC_JAL     7'b1101111
`define IFU_OPC_BRANCH  7'b1100011

// Compressed quadrant 01 and its funct3 codes
`define IFU_C_Q1        2'b01
`define IFU_C_F3_J      3'b101
`define IFU_C_F3_JAL    3'b001
`define IFU_C_F3_BEQZ   3'b110
`define IFU_C_F3_BNEZ   3'b111

// Sequential PC steps
`define IFU_STEP_32     32'd4
`define IFU_STEP_16     32'd2

`endif

// ==== logic/ifu_fetch_ctrl.sv ====
/*
  Request and response control. At most one fetch is outstanding; a new one
  is issued in the same cycle the previous response is taken
*/
`timescale 1ns/100ps

module ifu_fetch_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_ready,
  input  logic rsp_valid,
  input  logic halt_req,
  input  logic boot_req,
  input  logic flush_real,
  input  logic ir_in_ready,
  output logic req_valid,
  output logic req_fire,
  output logic rsp_ready,
  output logic ir_load,
  output logic halt_ack
);

  logic out_flag_r;
  logic rsp_fire;
  logic no_outs;
  logic new_req;
  logic halt_ack_r;

  assign rsp_fire = rsp_valid & rsp_ready;
  assign req_fire = req_valid & req_ready;

  // Port is free when idle, or the pending response is already back
  assign no_outs = ~out_flag_r | rsp_valid;

  ////////////////////////////////////////////////////////////
  // Request and response handshakes
  ////////////////////////////////////////////////////////////

  // Sequential fetch rides on the response that feeds the IR
  assign new_req = rsp_valid & ir_in_ready & ~halt_req;

  // Redirects ignore halt and IR state
  assign req_valid = (boot_req | flush_real | new_req) & no_outs;

  // Stale responses are drained under flush; otherwise take the
  // response only when its follow-on request can go out too
  assign rsp_ready = flush_real | (ir_in_ready & ~halt_req & req_ready);

  // Response to the IR unless it belongs to a flushed stream
  assign ir_load = rsp_fire & ~flush_real;

  // Outstanding flag, set wins over clear
  always_ff @(posedge clk) begin
    if (reset) begin
      out_flag_r <= 1'b0;
    end else if (req_fire) begin
      out_flag_r <= 1'b1;
    end else if (rsp_fire) begin
      out_flag_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Halt acknowledge
  ////////////////////////////////////////////////////////////

  // A waiting response counts as done, it is not consumed while halted
  always_ff @(posedge clk) begin
    if (reset) begin
      halt_ack_r <= 1'b0;
    end else if (halt_req & ~halt_ack_r & no_outs) begin
      halt_ack_r <= 1'b1;
    end else if (halt_ack_r & ~halt_req) begin
      halt_ack_r <= 1'b0;
    end
  end

  assign halt_ack = halt_ack_r;

endmodule

// ==== logic/ifu_ifetch.sv ====
/*
  Fetch stage top. Flush is accepted every cycle, so there is no ack;
  misaligned fetch cannot occur with RVC and has no port
*/
`timescale 1ns/100ps

module ifu_ifetch
  import ifu_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  pc_t    pc_rtvec,
  output pc_t    inspect_pc,
  // Fetch request
  output logic   req_valid,
  input  logic   req_ready,
  output pc_t    req_pc,
  output logic   req_seq,
  // Fetch response
  input  logic   rsp_valid,
  output logic   rsp_ready,
  input  logic   rsp_err,
  input  instr_u rsp_instr,
  // IR to execute
  output logic   ir_valid,
  input  logic   ir_ready,
  output instr_u ir_instr,
  output pc_t    ir_pc,
  output logic   ir_buserr,
  output logic   ir_prdt_taken,
  // Pipeline flush and halt
  input  logic   flush_req,
  input  pc_t    flush_add_op1,
  input  pc_t    flush_add_op2,
  input  logic   halt_req,
  output logic   halt_ack
);

  logic dec_rv32;
  logic dec_jal;
  logic dec_bxx;
  pc_t  dec_bjp_imm;
  logic boot_req;
  logic flush_real;
  logic prdt_taken;
  logic req_fire;
  logic ir_load;
  logic ir_in_ready;

  // Pre-decode of the word on the response channel
  ifu_minidec u_minidec (
    .instr   (rsp_instr),
    .rv32    (dec_rv32),
    .jal     (dec_jal),
    .bxx     (dec_bxx),
    .bjp_imm (dec_bjp_imm)
  );

  ifu_pc_gen u_pc_gen (
    .clk           (clk),
    .reset         (reset),
    .pc_rtvec      (pc_rtvec),
    .flush_req     (flush_req),
    .flush_add_op1 (flush_add_op1),
    .flush_add_op2 (flush_add_op2),
    .req_fire      (req_fire),
    .rv32          (dec_rv32),
    .jal           (dec_jal),
    .bxx           (dec_bxx),
    .bjp_imm       (dec_bjp_imm),
    .pc            (inspect_pc),
    .req_pc        (req_pc),
    .req_seq       (req_seq),
    .boot_req      (boot_req),
    .flush_real    (flush_real),
    .prdt_taken    (prdt_taken)
  );

  ifu_fetch_ctrl u_fetch_ctrl (
    .clk         (clk),
    .reset       (reset),
    .req_ready   (req_ready),
    .rsp_valid   (rsp_valid),
    .halt_req    (halt_req),
    .boot_req    (boot_req),
    .flush_real  (flush_real),
    .ir_in_ready (ir_in_ready),
    .req_valid   (req_valid),
    .req_fire    (req_fire),
    .rsp_ready   (rsp_ready),
    .ir_load     (ir_load),
    .halt_ack    (halt_ack)
  );

  // PC for the IR comes from the PC register, not the request
  ifu_ir_stage u_ir_stage (
    .clk           (clk),
    .reset         (reset),
    .ir_load       (ir_load),
    .flush_req     (flush_req),
    .rv32          (dec_rv32),
    .rsp_err       (rsp_err),
    .prdt_taken    (prdt_taken),
    .rsp_instr     (rsp_instr),
    .pc            (inspect_pc),
    .ir_ready      (ir_ready),
    .ir_valid      (ir_valid),
    .ir_instr      (ir_instr),
    .ir_pc         (ir_pc),
    .ir_buserr     (ir_buserr),
    .ir_prdt_taken (ir_prdt_taken),
    .ir_in_ready   (ir_in_ready)
  );

endmodule

// ==== logic/ifu_ir_stage.sv ====
/*
  Instruction register toward execute. For compressed code the upper
  halfword is not reloaded and shows the last full-length instruction
*/
`timescale 1ns/100ps

module ifu_ir_stage
  import ifu_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   ir_load,
  input  logic   flush_req,
  input  logic   rv32,
  input  logic   rsp_err,
  input  logic   prdt_taken,
  input  instr_u rsp_instr,
  input  pc_t    pc,
  input  logic   ir_ready,
  output logic   ir_valid,
  output instr_u ir_instr,
  output pc_t    ir_pc,
  output logic   ir_buserr,
  output logic   ir_prdt_taken,
  output logic   ir_in_ready
);

  logic        ir_valid_r;
  logic        ir_valid_clr;
  logic [15:0] ir_hi_r;
  logic [15:0] ir_lo_r;
  pc_t         ir_pc_r;
  logic        ir_err_r;
  logic        ir_prdt_r;

  // Taken by execute, or killed by a flush
  assign ir_valid_clr = (ir_valid_r & ir_ready) | (flush_req & ir_valid_r);

  // Empty, or emptying this cycle
  assign ir_in_ready = ~ir_valid_r | ir_valid_clr;

  ////////////////////////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////////////////////////

  // Load and flush never coincide, load still wins
  always_ff @(posedge clk) begin
    if (reset) begin
      ir_valid_r <= 1'b0;
    end else if (ir_load) begin
      ir_valid_r <= 1'b1;
    end else if (ir_valid_clr) begin
      ir_valid_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir_lo_r   <= rsp_instr[15:0];
      // PC register still points at the word being returned
      ir_pc_r   <= pc;
      ir_err_r  <= rsp_err;
      ir_prdt_r <= prdt_taken;
    end
  end

  // Upper half toggles only for 32-bit code
  always_ff @(posedge clk) begin
    if (ir_load & rv32) begin
      ir_hi_r <= rsp_instr.rvc.upper;
    end
  end

  assign ir_valid      = ir_valid_r;
  assign ir_instr      = {ir_hi_r, ir_lo_r};
  assign ir_pc         = ir_pc_r;
  assign ir_buserr     = ir_err_r;
  assign ir_prdt_taken = ir_prdt_r;

endmodule

// ==== logic/ifu_minidec.sv ====
/*
  Combinational pre-decode of the fetch response. Only length, direct jumps
  and conditional branches are recognized; JALR and C.JR count as plain code
*/
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_minidec
  import ifu_pkg::*;
(
  input  instr_u instr,
  output logic   rv32,
  output logic   jal,
  output logic   bxx,
  output pc_t    bjp_imm
);

  logic c_q1;
  logic jal_32;
  logic bxx_32;
  logic jal_16;
  logic bxx_16;
  pc_t  j_imm;
  pc_t  b_imm;
  pc_t  cj_imm;
  pc_t  cb_imm;

  // Quadrant 11 marks a full-length instruction
  assign rv32 = (instr.rvc.quadrant == 2'b11);
  assign c_q1 = (instr.rvc.quadrant == `IFU_C_Q1);

  ////////////////////////////////////////////////////////////
  // Class decode
  ////////////////////////////////////////////////////////////

  assign jal_32 = (instr.rv32.opcode == `IFU_OPC_JAL);
  assign bxx_32 = (instr.rv32.opcode == `IFU_OPC_BRANCH);

  // C.J and C.JAL share the CJ format
  assign jal_16 = c_q1 & ((instr.rvc.funct3 == `IFU_C_F3_J) |
                          (instr.rvc.funct3 == `IFU_C_F3_JAL));
  // Zero-test branches share the CB format
  assign bxx_16 = c_q1 & ((instr.rvc.funct3 == `IFU_C_F3_BEQZ) |
                          (instr.rvc.funct3 == `IFU_C_F3_BNEZ));

  assign jal = rv32 ? jal_32 : jal_16;
  assign bxx = rv32 ? bxx_32 : bxx_16;

  ////////////////////////////////////////////////////////////
  // Immediates, all sign-extended with bit 0 zero
  ////////////////////////////////////////////////////////////

  // J-type: imm[20|10:1|11|19:12] sits in bits 31:12
  assign j_imm = {{12{instr.rv32.funct7[6]}}, instr.rv32.rs1, instr.rv32.funct3,
                  instr.rv32.rs2[0], instr.rv32.funct7[5:0], instr.rv32.rs2[4:1],
                  1'b0};

  // B-type: imm[12|10:5] in funct7, imm[4:1|11] in rd
  assign b_imm = {{20{instr.rv32.funct7[6]}}, instr.rv32.rd[0],
                  instr.rv32.funct7[5:0], instr.rv32.rd[4:1], 1'b0};

  // CJ: offset[11|4|9:8|10|6|7|3:1|5] in bits 12:2
  assign cj_imm = {{21{instr.rvc.imm_h[2]}}, instr.rvc.rs1p[1], instr.rvc.imm_h[0],
                   instr.rvc.rs1p[2], instr.rvc.imm_l[4], instr.rvc.rs1p[0],
                   instr.rvc.imm_l[0], instr.rvc.imm_h[1], instr.rvc.imm_l[3:1],
                   1'b0};

  // CB: offset[8|4:3] in bits 12:10, offset[7:6|2:1|5] in bits 6:2
  assign cb_imm = {{24{instr.rvc.imm_h[2]}}, instr.rvc.imm_l[4:3], instr.rvc.imm_l[0],
                   instr.rvc.imm_h[1:0], instr.rvc.imm_l[2:1], 1'b0};

  // Pick the format matching length and class
  always_comb begin
    if (rv32) begin
      bjp_imm = jal_32 ? j_imm : b_imm;
    end else begin
      bjp_imm = jal_16 ? cj_imm : cb_imm;
    end
  end

endmodule

// ==== logic/ifu_pc_gen.sv ====
/*
  Next fetch address and PC register. A flush is always taken; if the request
  port is busy it is remembered and replayed from the PC register
*/
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_pc_gen
  import ifu_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  pc_t  pc_rtvec,
  input  logic flush_req,
  input  pc_t  flush_add_op1,
  input  pc_t  flush_add_op2,
  input  logic req_fire,
  input  logic rv32,
  input  logic jal,
  input  logic bxx,
  input  pc_t  bjp_imm,
  output pc_t  pc,
  output pc_t  req_pc,
  output logic req_seq,
  output logic boot_req,
  output logic flush_real,
  output logic prdt_taken
);

  logic reset_flag_r;
  logic boot_req_r;
  logic dly_flush_r;
  pc_t  pc_r;
  pc_t  add_op1;
  pc_t  add_op2;
  pc_t  pc_sum;
  pc_t  pc_nxt;

  ////////////////////////////////////////////////////////////
  // Boot request
  ////////////////////////////////////////////////////////////

  // Flag is high during reset and for one cycle after it
  always_ff @(posedge clk) begin
    if (reset) begin
      reset_flag_r <= 1'b1;
    end else begin
      reset_flag_r <= 1'b0;
    end
  end

  // Raised from the reset flag, held until its request handshakes
  always_ff @(posedge clk) begin
    if (reset) begin
      boot_req_r <= 1'b0;
    end else if (reset_flag_r & ~boot_req_r) begin
      boot_req_r <= 1'b1;
    end else if (boot_req_r & req_fire) begin
      boot_req_r <= 1'b0;
    end
  end

  assign boot_req = boot_req_r;

  ////////////////////////////////////////////////////////////
  // Delayed flush
  ////////////////////////////////////////////////////////////

  // Flush with no request handshake this cycle must be replayed
  always_ff @(posedge clk) begin
    if (reset) begin
      dly_flush_r <= 1'b0;
    end else if (flush_req & ~req_fire) begin
      dly_flush_r <= 1'b1;
    end else if (req_fire) begin
      dly_flush_r <= 1'b0;
    end
  end

  assign flush_real = flush_req | dly_flush_r;

  ////////////////////////////////////////////////////////////
  // Prediction and next PC
  ////////////////////////////////////////////////////////////

  // Jumps always, branches only when backward
  assign prdt_taken = jal | (bxx & bjp_imm[`IFU_PC_W-1]);

  // One shared adder, operands picked by priority
  always_comb begin
    if (flush_req) begin
      add_op1 = flush_add_op1;
      add_op2 = flush_add_op2;
    end else if (dly_flush_r) begin
      // PC register already holds the flush target
      add_op1 = pc_r;
      add_op2 = '0;
    end else if (prdt_taken) begin
      add_op1 = pc_r;
      add_op2 = bjp_imm;
    end else if (boot_req_r) begin
      add_op1 = pc_rtvec;
      add_op2 = '0;
    end else begin
      add_op1 = pc_r;
      add_op2 = rv32 ? `IFU_STEP_32 : `IFU_STEP_16;
    end
  end

  assign pc_sum = add_op1 + add_op2;
  // Halfword alignment, always
  assign pc_nxt = {pc_sum[`IFU_PC_W-1:1], 1'b0};

  // Only the plain step counts as sequential
  assign req_seq = ~flush_real & ~prdt_taken & ~boot_req_r;

  // PC follows the request, or jumps straight to a flush target
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_r <= '0;
    end else if (req_fire | flush_req) begin
      pc_r <= pc_nxt;
    end
  end

  assign pc     = pc_r;
  assign req_pc = pc_nxt;

endmodule

// ==== logic/ifu_pkg.sv ====
/*
  Types shared by the fetch stage. The instruction word is one 32-bit union,
  read as RV32 fields or as an RVC halfword with an unused upper half
*/
`include "ifu_consts.svh"

package ifu_pkg;

  // Fetch address
  typedef logic [`IFU_PC_W-1:0] pc_t;

  // Full-length encoding, R-type field split
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rv32_fields_t;

  // Compressed encoding in the low halfword
  // imm_h is bits 12:10, rs1p bits 9:7, imm_l bits 6:2
  typedef struct packed {
    logic [15:0] upper;
    logic [2:0]  funct3;
    logic [2:0]  imm_h;
    logic [2:0]  rs1p;
    logic [4:0]  imm_l;
    logic [1:0]  quadrant;
  } rvc_fields_t;

  // One fetched word, two decodings
  typedef union packed {
    rv32_fields_t rv32;
    rvc_fields_t  rvc;
  } instr_u;

endpackage

// ==== sim/ifu_tb.sv ====
/*
  Fetch stage testbench. Random memory, IR back-pressure, flush and halt from
  one LFSR; expected requests and IR entries come from a model of the fetch rules
*/
`timescale 1ns/100ps

module ifu_tb
  import ifu_pkg::*;
();

  localparam int IR_TARGET = 400;

  logic   clk;
  logic   reset;
  pc_t    pc_rtvec = 32'h0000_2000;
  pc_t    inspect_pc;
  logic   req_valid;
  logic   req_ready = 1'b0;
  pc_t    req_pc;
  logic   req_seq;
  logic   rsp_valid = 1'b0;
  logic   rsp_ready;
  logic   rsp_err = 1'b0;
  instr_u rsp_instr = '0;
  logic   ir_valid;
  logic   ir_ready = 1'b0;
  instr_u ir_instr;
  pc_t    ir_pc;
  logic   ir_buserr;
  logic   ir_prdt_taken;
  logic   flush_req = 1'b0;
  pc_t    flush_add_op1 = '0;
  pc_t    flush_add_op2 = '0;
  logic   halt_req = 1'b0;
  logic   halt_ack;

  // LFSR state and fetch model
  logic [31:0] lfsr_state = 32'd98721;
  int          n_after_reset = 0;
  int          ir_count = 0;
  int          halt_cnt = 0;
  logic        m_boot = 1'b1;
  logic        m_dly = 1'b0;
  logic        m_ack = 1'b0;
  pc_t         m_pc = '0;
  // Memory responder state
  // The cur_* values describe the word being returned
  logic        mem_outs = 1'b0;
  logic        mem_shown = 1'b0;
  pc_t         mem_addr = '0;
  logic [1:0]  mem_cnt = '0;
  logic [31:0] cur_word = '0;
  logic        cur_len4 = 1'b0;
  logic        cur_taken = 1'b0;
  pc_t         cur_imm = '0;
  logic        cur_err = 1'b0;
  logic [15:0] last_hi = '0;
  logic        hi_known = 1'b0;
  // Expected IR entries with the oldest at the front
  pc_t         q_pc[$];
  instr_u      q_instr[$];
  logic        q_hi_known[$];
  logic        q_err[$];
  logic        q_prdt[$];
  // Per-cycle scratch
  logic [31:0] tmp;
  pc_t         exp_pc;
  pc_t         tgt;
  logic        exp_seq;
  logic        exp_rdy;
  logic        rsp_fire_s;
  logic        req_fire_s;

  tb_clkgen u_clkgen (.clk(clk), .reset(reset));

  ifu_ifetch uut (
    .clk(clk), .reset(reset), .pc_rtvec(pc_rtvec), .inspect_pc(inspect_pc),
    .req_valid(req_valid), .req_ready(req_ready), .req_pc(req_pc), .req_seq(req_seq),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_err(rsp_err),
    .rsp_instr(rsp_instr), .ir_valid(ir_valid), .ir_ready(ir_ready),
    .ir_instr(ir_instr), .ir_pc(ir_pc), .ir_buserr(ir_buserr),
    .ir_prdt_taken(ir_prdt_taken), .flush_req(flush_req),
    .flush_add_op1(flush_add_op1), .flush_add_op2(flush_add_op2),
    .halt_req(halt_req), .halt_ack(halt_ack)
  );

  ////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  ////////////////////////////////////////////////////////////

  task automatic stop_fail();
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    stop_fail();
  endtask

  task automatic check_pc(input string what, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  // Upper half is compared only once a 32-bit word has passed the IR
  task automatic check_instr(input string what, input instr_u got, input instr_u exp,
                             input logic hi_chk);
    if (got[15:0] !== exp[15:0] || (hi_chk && got[31:16] !== exp[31:16])) begin
      report_error($sformatf("%s is %h, expected %h", what, got, exp));
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Random numbers and instruction encoders
  ////////////////////////////////////////////////////////////

  // Taps 32, 22, 2, 1; one step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_branch(input logic [12:0] imm, input logic [2:0] f3,
                                             input logic [9:0] regs);
    return {imm[12], imm[10:5], regs[9:5], regs[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  // C.J when sel is high, C.JAL otherwise
  function automatic logic [31:0] enc_cj(input logic [15:0] upper, input logic sel,
                                         input logic [11:0] off);
    return {upper, (sel ? 3'b101 : 3'b001), off[11], off[4], off[9:8], off[10],
            off[6], off[7], off[3:1], off[5], 2'b01};
  endfunction

  // C.BNEZ when sel is high, C.BEQZ otherwise
  function automatic logic [31:0] enc_cb(input logic [15:0] upper, input logic sel,
                                         input logic [8:0] off, input logic [2:0] rs);
    return {upper, (sel ? 3'b111 : 3'b110), off[8], off[4:3], rs, off[7:6], off[2:1],
            off[5], 2'b01};
  endfunction

  // Pick one random word and note its length, offset and predicted direction
  task automatic make_instr();
    logic [31:0] k;
    logic [31:0] r;
    logic [31:0] u;
    k = rand_bits(3);
    r = rand_bits(20);
    u = rand_bits(16);
    cur_taken = 1'b0;
    cur_imm = '0;
    case (k[2:0])
      3'd0, 3'd1: begin
        cur_word = {r[19:0], u[4:0], 7'b0010011};
        cur_len4 = 1'b1;
      end
      3'd2, 3'd3: begin
        // Quadrants 00 and 10 hold no jump or branch
        cur_word = {u[15:0], r[13:0], r[14], 1'b0};
        cur_len4 = 1'b0;
      end
      3'd4: begin
        cur_word = enc_jal({r[19:0], 1'b0}, u[4:0]);
        cur_imm = {{11{r[19]}}, r[19:0], 1'b0};
        cur_taken = 1'b1;
        cur_len4 = 1'b1;
      end
      3'd5: begin
        cur_word = enc_branch({r[11:0], 1'b0}, {u[0], 2'b00}, u[13:4]);
        cur_imm = {{19{r[11]}}, r[11:0], 1'b0};
        cur_taken = r[11];
        cur_len4 = 1'b1;
      end
      3'd6: begin
        cur_word = enc_cj(u[15:0], r[12], {r[10:0], 1'b0});
        cur_imm = {{20{r[10]}}, r[10:0], 1'b0};
        cur_taken = 1'b1;
        cur_len4 = 1'b0;
      end
      default: begin
        cur_word = enc_cb(u[15:0], r[12], {r[7:0], 1'b0}, r[15:13]);
        cur_imm = {{23{r[7]}}, r[7:0], 1'b0};
        cur_taken = r[7];
        cur_len4 = 1'b0;
      end
    endcase
    k = rand_bits(4);
    cur_err = (k[3:0] == 4'd0);
  endtask

  ////////////////////////////////////////////////////////////
  // Model, memory responder and stimulus on the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!reset) begin
      n_after_reset = n_after_reset + 1;
      // Boot timing
      if (n_after_reset == 1) check_flag("req_valid after reset", req_valid, 1'b0);
      if (n_after_reset == 2) begin
        check_flag("boot req_valid", req_valid, 1'b1);
        check_pc("boot req_pc", req_pc, pc_rtvec);
        check_flag("boot req_seq", req_seq, 1'b0);
      end

      // Response taken under flush, or when IR space, no halt and the request port agree
      exp_rdy = flush_req || m_dly ||
                ((q_pc.size() == 0 || ir_ready) && !halt_req && req_ready);
      check_flag("rsp_ready", rsp_ready, exp_rdy);

      // IR output against the oldest expected entry
      if (ir_valid === 1'b1) begin
        if (q_pc.size() == 0) report_error("ir_valid with no expected entry");
        check_pc("ir_pc", ir_pc, q_pc[0]);
        check_instr("ir_instr", ir_instr, q_instr[0], q_hi_known[0]);
        check_flag("ir_buserr", ir_buserr, q_err[0]);
        check_flag("ir_prdt_taken", ir_prdt_taken, q_prdt[0]);
        if (ir_ready || flush_req) begin
          if (ir_ready && !flush_req) ir_count = ir_count + 1;
          void'(q_pc.pop_front());
          void'(q_instr.pop_front());
          void'(q_hi_known.pop_front());
          void'(q_err.pop_front());
          void'(q_prdt.pop_front());
        end
      end else begin
        check_flag("ir_valid", ir_valid, 1'b0);
        if (q_pc.size() != 0) report_error("expected IR entry was not presented");
      end

      // PC register follows every request and every flush
      check_pc("inspect_pc", inspect_pc, m_pc);

      // Halt acknowledge waits for the outstanding fetch to come back
      check_flag("halt_ack", halt_ack, m_ack);
      if (halt_req && !m_ack && (!mem_outs || rsp_valid)) m_ack = 1'b1;
      else if (m_ack && !halt_req) m_ack = 1'b0;

      // Response handshake
      rsp_fire_s = rsp_valid && rsp_ready;
      if (rsp_fire_s) begin
        if (!flush_req && !m_dly) begin
          if (cur_len4) begin
            last_hi = cur_word[31:16];
            hi_known = 1'b1;
          end
          q_pc.push_back(mem_addr);
          q_instr.push_back({last_hi, cur_word[15:0]});
          q_hi_known.push_back(hi_known);
          q_err.push_back(cur_err);
          q_prdt.push_back(cur_taken);
        end
        mem_outs = 1'b0;
        mem_shown = 1'b0;
        rsp_valid <= 1'b0;
        rsp_instr <= '0;
        rsp_err <= 1'b0;
      end

      // Request handshake against the next-address rules
      req_fire_s = req_valid && req_ready;
      tgt = flush_add_op1 + flush_add_op2;
      tgt[0] = 1'b0;
      if (req_fire_s) begin
        if (mem_outs) report_error("second request while one is outstanding");
        exp_seq = 1'b0;
        if (flush_req) exp_pc = tgt;
        else if (m_dly) exp_pc = m_pc;
        else if (rsp_valid && cur_taken) exp_pc = m_pc + cur_imm;
        else if (m_boot) exp_pc = pc_rtvec;
        else begin
          if (!rsp_valid) report_error("sequential request without a response");
          exp_pc = m_pc + (cur_len4 ? 32'd4 : 32'd2);
          exp_seq = 1'b1;
        end
        // Only boot and flush redirects may go out during halt
        if (halt_req && !flush_req && !m_dly && !m_boot) begin
          report_error("normal request issued during halt");
        end
        check_pc("req_pc", req_pc, exp_pc);
        check_flag("req_seq", req_seq, exp_seq);
        m_pc = exp_pc;
        m_dly = 1'b0;
        m_boot = 1'b0;
        mem_outs = 1'b1;
        mem_addr = req_pc;
        tmp = rand_bits(2);
        mem_cnt = tmp[1:0];
        make_instr();
      end else if (flush_req) begin
        // Port busy so the target is kept for later
        m_pc = tgt;
        m_dly = 1'b1;
      end else if (mem_outs && !mem_shown) begin
        if (mem_cnt == 2'd0) begin
          rsp_valid <= 1'b1;
          rsp_instr <= cur_word;
          rsp_err <= cur_err;
          mem_shown = 1'b1;
        end else begin
          mem_cnt = mem_cnt - 2'd1;
        end
      end

      // Back-pressure on both sides
      tmp = rand_bits(2);
      req_ready <= (tmp[1:0] != 2'd0);
      tmp = rand_bits(2);
      ir_ready <= (tmp[1:0] != 2'd0);

      // Flush strobes and halt windows start after boot
      tmp = rand_bits(5);
      if (flush_req) begin
        flush_req <= 1'b0;
      end else if (!m_boot && tmp[4:0] == 5'd0) begin
        flush_req <= 1'b1;
        flush_add_op1 <= rand_bits(32);
        flush_add_op2 <= rand_bits(8);
      end
      tmp = rand_bits(6);
      if (halt_cnt > 0) begin
        halt_cnt = halt_cnt - 1;
        if (halt_cnt == 0) halt_req <= 1'b0;
      end else if (!m_boot && tmp[5:0] == 6'd0) begin
        halt_req <= 1'b1;
        tmp = rand_bits(4);
        halt_cnt = 4 + int'(tmp[3:0]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////

  initial begin
    int i;
    for (i = 0; i < 100 && reset !== 1'b0; i++) @(posedge clk);
    if (reset !== 1'b0) begin
      $display("Timeout: reset was never released");
      stop_fail();
    end
    for (i = 0; i < 40000 && ir_count < IR_TARGET; i++) @(posedge clk);
    if (ir_count < IR_TARGET) begin
      $display("Timeout: only %0d IR entries were handed over", ir_count);
      stop_fail();
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== sim/tb_clkgen.sv ====
/*
  Testbench clock and reset. 40 ns period, reset high for the first 10 cycles
*/
`timescale 1ns/100ps

module tb_clkgen (
  output logic clk,
  output logic reset
);

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== tb.f ====
+incdir+logic
logic/ifu_pkg.sv
logic/ifu_minidec.sv
logic/ifu_pc_gen.sv
logic/ifu_fetch_ctrl.sv
logic/ifu_ir_stage.sv
logic/ifu_ifetch.sv
sim/tb_clkgen.sv
sim/ifu_tb.sv
